// ==== Makefile ====
TOP := tb_sb_rx_hdr_decoder

.PHONY: all lint clean

all:
	verilator --binary --timing -j 0 --top-module $(TOP) -f sb_rx_hdr_decoder.f -Mdir obj_dir
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --top-module sb_rx_hdr_decoder -f sb_rx_hdr_decoder.f

clean:
	rm -rf obj_dir

// ==== sb_rx_hdr_decoder.f ====
+incdir+verif
src/sb_hdr_pkg.sv
src/sb_test_msg_decoder.sv
src/sb_mbinit_msg_decoder.sv
src/sb_mbtrain_msg_decoder.sv
src/sb_msg_decode_core.sv
src/sb_dec_output_reg.sv
src/sb_rx_hdr_decoder.sv
verif/tb_sb_rx_hdr_decoder.sv

// ==== src/sb_dec_output_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

// Output stage, one register between strobe and result
module sb_dec_output_reg (
	input  wire                          i_clk,
	input  wire                          i_rst_n,
	input  wire                          i_start_en,
	input  wire sb_hdr_pkg::dec_result_t i_result,
	input  wire sb_hdr_pkg::test_grp_e   i_test_grp,
	input  wire                          i_is_test,
	output sb_hdr_pkg::dec_result_t      o_result,
	output sb_hdr_pkg::test_grp_e        o_test_grp,
	output logic                         o_sweep_en,
	output logic                         o_dec_header_valid
);

	import sb_hdr_pkg::*;

	// **********************************************************************
	// Decoded result and point/sweep state
	// **********************************************************************

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_result   <= '0;
			o_test_grp <= TEST_GRP_0;
			o_sweep_en <= 1'b0;
		end
		else if (i_start_en)
		begin
			// Result loads on every strobe
			o_result   <= i_result;
			o_sweep_en <= i_is_test;
			// Group sticks across non-test messages
			if (i_is_test)
				o_test_grp <= i_test_grp;
		end
	end

	// **********************************************************************
	// Valid pulse
	// **********************************************************************

	// High the cycle after each strobe, low otherwise
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			o_dec_header_valid <= 1'b0;
		else
			o_dec_header_valid <= i_start_en;
	end

endmodule

`default_nettype wire

// ==== src/sb_hdr_pkg.sv ====
`default_nettype none

package sb_hdr_pkg;

	// **********************************************************************
	// Field widths and info bit positions
	// **********************************************************************

	// Decoded message number and info widths
	localparam int unsigned MSG_NO_W      = 4;
	localparam int unsigned MSG_INFO_W    = 3;

	// Test-class response carries its info in header info bits 5:4
	localparam int unsigned TEST_INFO_LSB = 4;
	localparam int unsigned TEST_INFO_W   = 2;

	// **********************************************************************
	// Message code nibbles
	// **********************************************************************

	// Class nibble, upper half of the message code
	typedef enum logic [3:0] {
		TEST       = 4'h8,
		SBINT      = 4'h9,
		MBINIT     = 4'hA,
		MBTRAIN    = 4'hB,
		RETRAIN    = 4'hC,
		TRAINERROR = 4'hE
	} msg_class_e;

	// Direction nibble, lower half of the message code
	typedef enum logic [3:0] {
		REQ  = 4'h5,
		RESP = 4'hA
	} msg_dir_e;

	// Point/sweep test group of a test message
	typedef enum logic [1:0] {
		TEST_GRP_0 = 2'd0,
		TEST_GRP_1 = 2'd1,
		TEST_GRP_2 = 2'd2,
		TEST_GRP_3 = 2'd3
	} test_grp_e;

	// Raw nibbles, any value may arrive on the link
	typedef struct packed {
		logic [3:0] class_nib;
		logic [3:0] dir_nib;
	} msg_code_t;

	// 64-bit sideband header, MSB first
	typedef struct packed {
		logic [7:0]  rsvd_hi;
		logic [15:0] msg_info;
		logic [7:0]  msg_subcode;
		logic [9:0]  rsvd_mid;
		msg_code_t   msg_code;
		logic [8:0]  rsvd_lo;
		// Carried for layout only, not decoded
		logic [4:0]  opcode;
	} sb_header_t;

	// **********************************************************************
	// Decode result
	// **********************************************************************

	typedef logic [MSG_NO_W-1:0]   msg_no_t;
	typedef logic [MSG_INFO_W-1:0] msg_info_t;

	typedef struct packed {
		msg_no_t   msg_no;
		msg_info_t msg_info;
	} dec_result_t;

	// Request/response number pair, zero for a bad direction
	function automatic msg_no_t pick_no(input msg_dir_e dir, input msg_no_t req_no,
		input msg_no_t resp_no);
		msg_no_t no;
		case (dir)
			REQ:     no = req_no;
			RESP:    no = resp_no;
			default: no = '0;
		endcase
		return no;
	endfunction

endpackage

`default_nettype wire

// ==== src/sb_mbinit_msg_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

// Mainband-init table, no class check in here
module sb_mbinit_msg_decoder (
	input  wire [7:0]                i_subcode,
	input  wire sb_hdr_pkg::msg_dir_e i_dir,
	input  wire [15:0]               i_info,
	output sb_hdr_pkg::dec_result_t  o_result
);

	import sb_hdr_pkg::*;

	always_comb
	begin
		o_result = '0;
		case (i_subcode)
			// Plain request/response pairs
			8'h00, 8'h02, 8'h03, 8'h09, 8'h0D, 8'h11:
				o_result.msg_no = pick_no(i_dir, 4'd1, 4'd2);
			8'h04, 8'h0A:
			begin
				o_result.msg_no = pick_no(i_dir, 4'd3, 4'd4);
				// Response returns header info bits
				if (i_dir == RESP)
					o_result.msg_info = i_info[MSG_INFO_W-1:0];
			end
			8'h08, 8'h0C, 8'h0F:
				o_result.msg_no = pick_no(i_dir, 4'd5, 4'd6);
			8'h0E, 8'h13:
				o_result.msg_no = pick_no(i_dir, 4'd3, 4'd4);
			8'h10:
				o_result.msg_no = pick_no(i_dir, 4'd7, 4'd8);
			8'h14:
			begin
				o_result.msg_no = pick_no(i_dir, 4'd5, 4'd6);
				// Here it is the request that carries info
				if (i_dir == REQ)
					o_result.msg_info = i_info[MSG_INFO_W-1:0];
			end
			// Unlisted subcode
			default:
				o_result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/sb_mbtrain_msg_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

// Mainband-train table, twelve message numbers
module sb_mbtrain_msg_decoder (
	input  wire [7:0]                i_subcode,
	input  wire sb_hdr_pkg::msg_dir_e i_dir,
	input  wire [15:0]               i_info,
	output sb_hdr_pkg::dec_result_t  o_result
);

	import sb_hdr_pkg::*;

	always_comb
	begin
		o_result = '0;
		case (i_subcode)
			// Messages 1/2
			8'h00, 8'h02, 8'h04, 8'h05, 8'h06, 8'h08, 8'h0A,
			8'h0C, 8'h0E, 8'h11, 8'h13, 8'h15, 8'h1B:
				o_result.msg_no = pick_no(i_dir, 4'd1, 4'd2);
			// Messages 3/4
			8'h01, 8'h03, 8'h07, 8'h09, 8'h0B, 8'h0D,
			8'h10, 8'h12, 8'h14, 8'h16, 8'h1C:
				o_result.msg_no = pick_no(i_dir, 4'd3, 4'd4);
			8'h17, 8'h1D:
				o_result.msg_no = pick_no(i_dir, 4'd5, 4'd6);
			8'h18:
				o_result.msg_no = pick_no(i_dir, 4'd7, 4'd8);
			8'h1E:
			begin
				o_result.msg_no = pick_no(i_dir, 4'd7, 4'd8);
				// Request passes low info bits through
				if (i_dir == REQ)
					o_result.msg_info = i_info[MSG_INFO_W-1:0];
			end
			8'h19:
				o_result.msg_no = pick_no(i_dir, 4'd9, 4'd10);
			8'h1F:
				o_result.msg_no = pick_no(i_dir, 4'd11, 4'd12);
			default:
				o_result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/sb_msg_decode_core.sv ====
`timescale 1ns/1ps
`default_nettype none

// Header classification and per-class result select
module sb_msg_decode_core (
	input  wire sb_hdr_pkg::sb_header_t i_header,
	output sb_hdr_pkg::dec_result_t     o_result,
	output sb_hdr_pkg::test_grp_e       o_test_grp,
	output logic                        o_is_test
);

	import sb_hdr_pkg::*;

	msg_class_e  msg_class;
	msg_dir_e    msg_dir;
	logic [7:0]  subcode;
	logic [15:0] info;
	logic        dir_ok;
	dec_result_t test_result;
	dec_result_t mbinit_result;
	dec_result_t mbtrain_result;
	dec_result_t sbint_result;
	dec_result_t retrain_result;
	dec_result_t trainerr_result;

	// **********************************************************************
	// Header fields
	// **********************************************************************

	// Unknown nibbles pass the cast and miss every case below
	assign msg_class = msg_class_e'(i_header.msg_code.class_nib);
	assign msg_dir   = msg_dir_e'(i_header.msg_code.dir_nib);
	assign subcode   = i_header.msg_subcode;
	assign info      = i_header.msg_info;
	assign dir_ok    = (msg_dir == REQ) || (msg_dir == RESP);
	assign o_is_test = (msg_class == TEST);

	// **********************************************************************
	// Large class tables
	// **********************************************************************

	sb_test_msg_decoder test_dec_inst (
		.i_subcode  (subcode),
		.i_dir      (msg_dir),
		.i_info     (info),
		.o_result   (test_result),
		.o_test_grp (o_test_grp)
	);

	sb_mbinit_msg_decoder mbinit_dec_inst (
		.i_subcode (subcode),
		.i_dir     (msg_dir),
		.i_info    (info),
		.o_result  (mbinit_result)
	);

	sb_mbtrain_msg_decoder mbtrain_dec_inst (
		.i_subcode (subcode),
		.i_dir     (msg_dir),
		.i_info    (info),
		.o_result  (mbtrain_result)
	);

	// **********************************************************************
	// Small class tables
	// **********************************************************************

	always_comb
	begin
		sbint_result    = '0;
		retrain_result  = '0;
		trainerr_result = '0;
		// Sideband init, 00 decodes in any direction
		if (subcode == 8'h00)
			sbint_result.msg_no = 4'd3;
		else if (subcode == 8'h01)
			sbint_result.msg_no = pick_no(msg_dir, 4'd1, 4'd2);
		// Retrain, info follows header on both directions
		if (subcode == 8'h01 && dir_ok)
		begin
			retrain_result.msg_no   = pick_no(msg_dir, 4'd1, 4'd2);
			retrain_result.msg_info = info[MSG_INFO_W-1:0];
		end
		// Train error numbers run downward
		if (subcode == 8'h00)
			trainerr_result.msg_no = pick_no(msg_dir, 4'd15, 4'd14);
	end

	// **********************************************************************
	// Class select
	// **********************************************************************

	always_comb
	begin
		case (msg_class)
			TEST:       o_result = test_result;
			SBINT:      o_result = sbint_result;
			MBINIT:     o_result = mbinit_result;
			MBTRAIN:    o_result = mbtrain_result;
			RETRAIN:    o_result = retrain_result;
			TRAINERROR: o_result = trainerr_result;
			default:    o_result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/sb_rx_hdr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

// Sideband receive header decoder, top level
module sb_rx_hdr_decoder (
	input  wire                         i_clk,
	input  wire                         i_rst_n,
	input  wire                         i_start_en,
	input  wire sb_hdr_pkg::sb_header_t i_header,
	output sb_hdr_pkg::dec_result_t     o_result,
	output sb_hdr_pkg::test_grp_e       o_test_grp,
	output logic                        o_sweep_en,
	output logic                        o_dec_header_valid
);

	import sb_hdr_pkg::*;

	// Combinational decode to register stage
	dec_result_t core_result;
	test_grp_e   core_test_grp;
	logic        core_is_test;

	// Classify and look up
	sb_msg_decode_core sb_msg_decode_core_inst (
		.i_header   (i_header),
		.o_result   (core_result),
		.o_test_grp (core_test_grp),
		.o_is_test  (core_is_test)
	);

	// Sample on the start strobe
	sb_dec_output_reg sb_dec_output_reg_inst (
		.i_clk              (i_clk),
		.i_rst_n            (i_rst_n),
		.i_start_en         (i_start_en),
		.i_result           (core_result),
		.i_test_grp         (core_test_grp),
		.i_is_test          (core_is_test),
		.o_result           (o_result),
		.o_test_grp         (o_test_grp),
		.o_sweep_en         (o_sweep_en),
		.o_dec_header_valid (o_dec_header_valid)
	);

endmodule

`default_nettype wire

// ==== src/sb_test_msg_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

// Test-class table, also sorts subcodes into point/sweep groups
module sb_test_msg_decoder (
	input  wire [7:0]                i_subcode,
	input  wire sb_hdr_pkg::msg_dir_e i_dir,
	input  wire [15:0]               i_info,
	output sb_hdr_pkg::dec_result_t  o_result,
	output sb_hdr_pkg::test_grp_e    o_test_grp
);

	import sb_hdr_pkg::*;

	// **********************************************************************
	// Message number and info
	// **********************************************************************

	always_comb
	begin
		// Unmatched subcodes fall through as 0/0
		o_result = '0;
		case (i_subcode)
			8'h01, 8'h05, 8'h07, 8'h0A:
				o_result.msg_no = pick_no(i_dir, 4'd1, 4'd2);
			8'h02:
				o_result.msg_no = pick_no(i_dir, 4'd3, 4'd4);
			8'h03, 8'h0B:
			begin
				o_result.msg_no = pick_no(i_dir, 4'd5, 4'd6);
				// Response reports two info bits
				if (i_dir == RESP)
					o_result.msg_info = msg_info_t'(i_info[TEST_INFO_LSB +: TEST_INFO_W]);
			end
			8'h04, 8'h09, 8'h0D:
				o_result.msg_no = pick_no(i_dir, 4'd7, 4'd8);
			8'h06, 8'h08:
				o_result.msg_no = pick_no(i_dir, 4'd5, 4'd6);
			// Direction ignored here
			8'h0C:
				o_result.msg_no = 4'd9;
			default:
				o_result = '0;
		endcase
	end

	// **********************************************************************
	// Point/sweep group
	// **********************************************************************

	always_comb
	begin
		case (i_subcode)
			8'h01, 8'h03, 8'h04:        o_test_grp = TEST_GRP_0;
			8'h05, 8'h06:               o_test_grp = TEST_GRP_1;
			8'h07, 8'h08, 8'h09:        o_test_grp = TEST_GRP_2;
			8'h0A, 8'h0B, 8'h0C, 8'h0D: o_test_grp = TEST_GRP_3;
			// Includes subcode 02
			default:                    o_test_grp = TEST_GRP_0;
		endcase
	end

endmodule

`default_nettype wire

// ==== verif/sb_rx_hdr_decoder_ref.svh ====
`ifndef SB_RX_HDR_DECODER_REF_SVH
`define SB_RX_HDR_DECODER_REF_SVH

// **********************************************************************
// Reference decode of one header
// **********************************************************************

function automatic dec_result_t ref_decode(input sb_header_t h);
	dec_result_t r;
	logic [3:0]  cls;
	logic [7:0]  sc;
	logic        req;
	logic        rsp;
	logic        any_dir;
	logic [7:0]  pr;
	cls = h.msg_code.class_nib;
	sc  = h.msg_subcode;
	req = (h.msg_code.dir_nib == REQ);
	rsp = (h.msg_code.dir_nib == RESP);
	// Request number in the high nibble, response number in the low one
	case (cls)
		TEST:
			case (sc)
				8'h01, 8'h05, 8'h07, 8'h0A: pr = 8'h12;
				8'h02:                      pr = 8'h34;
				8'h03, 8'h0B, 8'h06, 8'h08: pr = 8'h56;
				8'h04, 8'h09, 8'h0D:        pr = 8'h78;
				8'h0C:                      pr = 8'h99;
				default:                    pr = 8'h00;
			endcase
		SBINT:
			pr = (sc == 8'h00) ? 8'h33 : (sc == 8'h01) ? 8'h12 : 8'h00;
		MBINIT:
			case (sc)
				8'h00, 8'h02, 8'h03, 8'h09, 8'h0D, 8'h11: pr = 8'h12;
				8'h04, 8'h0A, 8'h0E, 8'h13:               pr = 8'h34;
				8'h08, 8'h0C, 8'h0F, 8'h14:               pr = 8'h56;
				8'h10:                                    pr = 8'h78;
				default:                                  pr = 8'h00;
			endcase
		MBTRAIN:
			case (sc)
				8'h00, 8'h02, 8'h04, 8'h05, 8'h06, 8'h08, 8'h0A,
				8'h0C, 8'h0E, 8'h11, 8'h13, 8'h15, 8'h1B:  pr = 8'h12;
				8'h01, 8'h03, 8'h07, 8'h09, 8'h0B, 8'h0D,
				8'h10, 8'h12, 8'h14, 8'h16, 8'h1C:         pr = 8'h34;
				8'h17, 8'h1D:                              pr = 8'h56;
				8'h18, 8'h1E:                              pr = 8'h78;
				8'h19:                                     pr = 8'h9A;
				8'h1F:                                     pr = 8'hBC;
				default:                                   pr = 8'h00;
			endcase
		RETRAIN:
			pr = (sc == 8'h01) ? 8'h12 : 8'h00;
		TRAINERROR:
			pr = (sc == 8'h00) ? 8'hFE : 8'h00;
		default:
			pr = 8'h00;
	endcase
	// Rows that ignore the direction nibble
	any_dir = (cls == TEST && sc == 8'h0C) || (cls == SBINT && sc == 8'h00);
	r = '0;
	if (any_dir || req)
		r.msg_no = pr[7:4];
	else if (rsp)
		r.msg_no = pr[3:0];
	// Info taken from the header, all other rows report 0
	if (rsp && cls == TEST && (sc == 8'h03 || sc == 8'h0B))
		r.msg_info = {1'b0, h.msg_info[5:4]};
	else if (rsp && cls == MBINIT && (sc == 8'h04 || sc == 8'h0A))
		r.msg_info = h.msg_info[2:0];
	else if (req && ((cls == MBINIT && sc == 8'h14) || (cls == MBTRAIN && sc == 8'h1E)))
		r.msg_info = h.msg_info[2:0];
	else if ((req || rsp) && cls == RETRAIN && sc == 8'h01)
		r.msg_info = h.msg_info[2:0];
	return r;
endfunction

// Group after a strobe, non-test headers keep the held one
function automatic test_grp_e ref_held_grp(input sb_header_t h, input test_grp_e held);
	test_grp_e g;
	g = held;
	if (h.msg_code.class_nib == TEST)
	begin
		case (h.msg_subcode)
			8'h05, 8'h06:               g = TEST_GRP_1;
			8'h07, 8'h08, 8'h09:        g = TEST_GRP_2;
			8'h0A, 8'h0B, 8'h0C, 8'h0D: g = TEST_GRP_3;
			// 01, 03, 04 and every unlisted subcode
			default:                    g = TEST_GRP_0;
		endcase
	end
	return g;
endfunction

// **********************************************************************
// Random source and compare tasks
// **********************************************************************

logic [31:0] rng_state = 32'd5282;

function automatic logic [31:0] xorshift32();
	logic [31:0] x;
	x = rng_state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rng_state = x;
	return x;
endfunction

task automatic check_result(input string sig, input dec_result_t got, input dec_result_t exp);
	if (got !== exp)
	begin
		$display("MISMATCH time=%0t %s got no=%0d info=%0d expected no=%0d info=%0d",
			$time, sig, got.msg_no, got.msg_info, exp.msg_no, exp.msg_info);
		abort_run();
	end
endtask

task automatic check_test_grp(input string sig, input test_grp_e got, input test_grp_e exp);
	if (got !== exp)
	begin
		$display("MISMATCH time=%0t %s got %0d expected %0d", $time, sig, got, exp);
		abort_run();
	end
endtask

task automatic check_flag(input string sig, input logic got, input logic exp);
	if (got !== exp)
	begin
		$display("MISMATCH time=%0t %s got %b expected %b", $time, sig, got, exp);
		abort_run();
	end
endtask

`endif

// ==== verif/tb_sb_rx_hdr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sb_rx_hdr_decoder;

	import sb_hdr_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int DRV_DLY    = 1;
	localparam int RST_CYCLES = 10;
	localparam int N_RAND     = 200;
	localparam int N_GAP      = 100;
	// Strobe count of table sweep, nibble sweep, fixed cases and random runs
	localparam int N_STROBES  = 6 * 32 * 2 + 16 * 16 + 9 + N_RAND + N_GAP;
	// Gaps of up to two cycles plus the fixed idle stretches
	localparam int N_IDLE     = 2 * N_GAP + 20;
	localparam int WATCHDOG_NS = 2 * (RST_CYCLES + N_STROBES + N_IDLE) * CLK_PERIOD;

	logic        i_clk;
	logic        i_rst_n;
	logic        i_start_en;
	sb_header_t  i_header;
	dec_result_t o_result;
	test_grp_e   o_test_grp;
	logic        o_sweep_en;
	logic        o_dec_header_valid;

	// Expected state follows the strobe seen one cycle earlier
	dec_result_t exp_result;
	test_grp_e   exp_grp;
	logic        exp_sweep;
	logic        exp_valid;

	task automatic abort_run();
		$display("Test failures found");
		$fatal(1, "Simulation stopped after an error");
	endtask

	`include "sb_rx_hdr_decoder_ref.svh"

	sb_rx_hdr_decoder sb_rx_hdr_decoder_inst (
		.i_clk              (i_clk),
		.i_rst_n            (i_rst_n),
		.i_start_en         (i_start_en),
		.i_header           (i_header),
		.o_result           (o_result),
		.o_test_grp         (o_test_grp),
		.o_sweep_en         (o_sweep_en),
		.o_dec_header_valid (o_dec_header_valid)
	);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	// **********************************************************************
	// Stimulus helpers
	// **********************************************************************

	function automatic sb_header_t make_hdr(input logic [3:0] cls, input logic [3:0] dir,
		input logic [7:0] sc);
		sb_header_t h;
		// Noise in info, reserved fields and opcode
		h = {xorshift32(), xorshift32()};
		h.msg_code.class_nib = cls;
		h.msg_code.dir_nib   = dir;
		h.msg_subcode        = sc;
		return h;
	endfunction

	function automatic logic [3:0] class_of(input int idx);
		case (idx)
			0:       return TEST;
			1:       return SBINT;
			2:       return MBINIT;
			3:       return MBTRAIN;
			4:       return RETRAIN;
			default: return TRAINERROR;
		endcase
	endfunction

	task automatic strobe(input sb_header_t h);
		@(posedge i_clk);
		#DRV_DLY;
		i_start_en = 1'b1;
		i_header   = h;
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge i_clk);
			#DRV_DLY;
			i_start_en = 1'b0;
		end
	endtask

	// **********************************************************************
	// Checker compares on every falling edge out of reset
	// **********************************************************************

	always @(negedge i_clk)
	begin
		if (!i_rst_n)
		begin
			exp_result = '0;
			exp_grp    = TEST_GRP_0;
			exp_sweep  = 1'b0;
			exp_valid  = 1'b0;
		end
		else
		begin
			check_flag("o_dec_header_valid", o_dec_header_valid, exp_valid);
			check_result("o_result", o_result, exp_result);
			check_test_grp("o_test_grp", o_test_grp, exp_grp);
			check_flag("o_sweep_en", o_sweep_en, exp_sweep);
			// Strobe now on the inputs shows up after the next edge
			exp_valid = i_start_en;
			if (i_start_en)
			begin
				exp_result = ref_decode(i_header);
				exp_grp    = ref_held_grp(i_header, exp_grp);
				exp_sweep  = (i_header.msg_code.class_nib == TEST);
			end
		end
	end

	initial
	begin
		#WATCHDOG_NS;
		$display("Timeout, the test sequence did not finish within %0d ns", WATCHDOG_NS);
		abort_run();
	end

	// **********************************************************************
	// Test sequence
	// **********************************************************************

	initial
	begin
		int c;
		int sc;
		int d;
		int k;
		i_clk      = 1'b0;
		i_rst_n    = 1'b0;
		i_start_en = 1'b0;
		i_header   = '0;
		repeat (RST_CYCLES) @(posedge i_clk);
		#DRV_DLY;
		i_rst_n = 1'b1;
		// Quiet outputs after reset
		idle(5);
		// Every class and subcode 00 to 1F in both directions
		for (c = 0; c < 6; c++)
			for (sc = 0; sc < 32; sc++)
				for (d = 0; d < 2; d++)
					strobe(make_hdr(class_of(c), (d != 0) ? RESP : REQ, sc[7:0]));
		idle(2);
		// Sweep enable and held group
		strobe(make_hdr(TEST, REQ, 8'h0A));
		idle(1);
		check_flag("o_sweep_en", o_sweep_en, 1'b1);
		check_test_grp("o_test_grp", o_test_grp, TEST_GRP_3);
		strobe(make_hdr(MBINIT, REQ, 8'h00));
		idle(1);
		check_flag("o_sweep_en", o_sweep_en, 1'b0);
		check_test_grp("o_test_grp", o_test_grp, TEST_GRP_3);
		// All class and direction nibbles where bad ones must give 0/0
		for (c = 0; c < 16; c++)
			for (d = 0; d < 16; d++)
				strobe(make_hdr(c[3:0], d[3:0], 8'(xorshift32() % 32)));
		// Any-direction rows with bad nibbles, unknown class, unlisted subcode
		strobe(make_hdr(TEST, 4'h0, 8'h0C));
		strobe(make_hdr(TEST, 4'hF, 8'h0C));
		strobe(make_hdr(SBINT, 4'h3, 8'h00));
		strobe(make_hdr(4'hD, REQ, 8'h01));
		strobe(make_hdr(MBINIT, RESP, 8'h05));
		strobe(make_hdr(TEST, 4'h6, 8'h03));
		strobe(make_hdr(TRAINERROR, 4'h0, 8'h00));
		idle(3);
		// Random back-to-back run
		for (k = 0; k < N_RAND; k++)
			strobe(make_hdr(class_of(xorshift32() % 6),
				(xorshift32() % 2 != 0) ? RESP : REQ, 8'(xorshift32() % 32)));
		// Random run with gaps of zero to two cycles
		for (k = 0; k < N_GAP; k++)
		begin
			strobe(make_hdr(class_of(xorshift32() % 6),
				(xorshift32() % 2 != 0) ? RESP : REQ, 8'(xorshift32() % 32)));
			idle(xorshift32() % 3);
		end
		idle(3);
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire
